//--- common/soc_periph_config.svh
// widths, address map, register offsets and event bit positions shared by RTL and testbench
`ifndef SOC_PERIPH_CONFIG_SVH
`define SOC_PERIPH_CONFIG_SVH

`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32
`define N_GPIO 32

// slot decode on paddr[11:8]
`define N_PERIPH 3
`define PERIPH_SEL_LSB 8
`define PERIPH_SEL_MSB 11
`define REG_OFFS_MSB 7  // register offset within a slot
`define SOC_CTRL_IDX 0
`define GPIO_IDX 1
`define TIMER_IDX 2

// soc control
`define SOC_INFO_VALUE 32'h0003_0001  // 3 slots, rev 1
`define BOOTADDR_RESET 32'h1c00_8080
`define SOC_CTRL_INFO 8'h00
`define SOC_CTRL_BOOTADDR 8'h04
`define SOC_CTRL_FETCHEN 8'h08
`define SOC_CTRL_SOFT_RESET 8'h0C

// gpio
`define GPIO_DIR 8'h00
`define GPIO_OUT 8'h04
`define GPIO_IN 8'h08
`define GPIO_INTEN 8'h0C
`define GPIO_INTSTATUS 8'h10  // read clears

// timer
`define TIMER_CFG 8'h00  // bit 0 enable, bit 1 ref clock mode
`define TIMER_COUNT 8'h04
`define TIMER_CMP 8'h08

// fc event vector bits
`define EVT_TIMER_MTIME 7
`define EVT_TIMER_LO 16
`define EVT_REF_RISE 18
`define EVT_REF_FALL 19
`define EVT_GPIO 20

`endif

//--- common/soc_periph_pkg.sv
// bus and event types shared by every block of the apb peripheral subsystem
`include "soc_periph_config.svh"

package soc_periph_pkg;

  ////////////////////
  // apb request, master to slave
  ////////////////////
  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;   // full byte address
    logic [`APB_DATA_WIDTH-1:0] pwdata;  // write data
    logic                       pwrite;  // 1 write, 0 read
    logic                       psel;    // slave select
    logic                       penable; // access phase
  } apb_req_t;

  ////////////////////
  // apb response, slave to master
  ////////////////////
  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;  // valid in access phase
    logic                       pready;  // zero wait state everywhere
    logic                       pslverr; // unmapped slot only
  } apb_rsp_t;

  // events towards the fabric controller
  // bit 7 and 16 timer, 18/19 ref clock edges, 20 gpio
  typedef logic [31:0] fc_event_t;

endpackage

//--- hw/sync_wedge.sv
// two-flop synchronizer with one extra stage for rise and fall pulses, any packed payload
`timescale 1ns/10ps

module sync_wedge #(
  parameter type T = logic  // single bit or vector
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  T     serial_i,  // asynchronous input
  output T     serial_o,  // synchronized value
  output T     r_edge_o,  // one cycle per rising edge
  output T     f_edge_o   // one cycle per falling edge
);

  T sync_q0;  // metastability stage
  T sync_q1;  // stable stage
  T dly_q;    // previous stable value

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q0 <= '0;
      sync_q1 <= '0;
      dly_q   <= '0;
    end else begin
      sync_q0 <= serial_i;
      sync_q1 <= sync_q0;
      dly_q   <= sync_q1;  // one cycle behind output
    end
  end

  assign serial_o = sync_q1;

  // bitwise edge detect between the last two stages
  assign r_edge_o = sync_q1 & ~dly_q;
  assign f_edge_o = ~sync_q1 & dly_q;

endmodule

//--- hw/periph_bus_decoder.sv
// decodes the single apb slave port onto the peripheral slots and returns the selected response
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module periph_bus_decoder (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  soc_periph_pkg::apb_req_t                    apb_req_i,
  output soc_periph_pkg::apb_rsp_t                    apb_rsp_o,
  output soc_periph_pkg::apb_req_t [`N_PERIPH-1:0]    slv_req_o,
  input  soc_periph_pkg::apb_rsp_t [`N_PERIPH-1:0]    slv_rsp_i
);

  localparam int SLOT_W = `PERIPH_SEL_MSB - `PERIPH_SEL_LSB + 1;

  logic [SLOT_W-1:0] slot;    // addressed slot
  logic              mapped;  // slot exists

  assign slot   = apb_req_i.paddr[`PERIPH_SEL_MSB:`PERIPH_SEL_LSB];
  assign mapped = (slot < SLOT_W'(`N_PERIPH));

  ////////////////////
  // request fan-out
  ////////////////////
  always_comb begin
    for (int i = 0; i < `N_PERIPH; i++) begin
      slv_req_o[i]      = apb_req_i;  // address, data and strobes shared
      slv_req_o[i].psel = apb_req_i.psel && (slot == SLOT_W'(i));  // one-hot select
    end
  end

  ////////////////////
  // response merge
  ////////////////////
  always_comb begin
    // default is the error answer for holes in the map
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b1;
    if (mapped) begin
      for (int i = 0; i < `N_PERIPH; i++) begin
        if (slot == SLOT_W'(i)) begin
          apb_rsp_o = slv_rsp_i[i];  // pass through, no register stage
        end
      end
    end
  end

  // master must never enter an access phase on a deselected bus
  penable_needs_psel : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    apb_req_i.penable |-> apb_req_i.psel
  ) else $error("penable high without psel");

endmodule

//--- hw/apb_soc_ctrl.sv
// soc control registers, boot address, fetch enable, info word and soft reset for the peripherals
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module apb_soc_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output logic [31:0]              fc_bootaddr_o,
  output logic                     fc_fetchen_o,
  output logic                     soft_reset_o
);

  logic [`REG_OFFS_MSB:0] offs;
  logic                   wr_en;
  logic [31:0]            bootaddr_q;
  logic                   fetchen_q;
  logic                   soft_reset_q;

  assign offs  = apb_req_i.paddr[`REG_OFFS_MSB:0];
  assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bootaddr_q   <= `BOOTADDR_RESET;
      fetchen_q    <= 1'b0;
      soft_reset_q <= 1'b0;
    end else begin
      if (wr_en && offs == `SOC_CTRL_BOOTADDR) bootaddr_q <= apb_req_i.pwdata;
      if (wr_en && offs == `SOC_CTRL_FETCHEN) fetchen_q <= apb_req_i.pwdata[0];
      // access phase lasts one cycle, so this is a single pulse
      soft_reset_q <= wr_en && offs == `SOC_CTRL_SOFT_RESET && apb_req_i.pwdata[0];
    end
  end

  assign fc_bootaddr_o = bootaddr_q;
  assign fc_fetchen_o  = fetchen_q;
  assign soft_reset_o  = soft_reset_q;

  ////////////////////
  // read back
  ////////////////////
  always_comb begin
    apb_rsp_o.pready  = 1'b1;  // zero wait state
    apb_rsp_o.pslverr = 1'b0;
    case (offs)
      `SOC_CTRL_INFO:     apb_rsp_o.prdata = `SOC_INFO_VALUE;
      `SOC_CTRL_BOOTADDR: apb_rsp_o.prdata = bootaddr_q;
      `SOC_CTRL_FETCHEN:  apb_rsp_o.prdata = {31'b0, fetchen_q};
      default:            apb_rsp_o.prdata = '0;  // soft reset reads as zero
    endcase
  end

  // the peripheral reset it drives must release after one cycle
  soft_reset_one_cycle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    soft_reset_o |=> !soft_reset_o
  ) else $error("soft reset pulse longer than one cycle");

endmodule

//--- gpio/apb_gpio.sv
// gpio block with direction, output, synchronized input and masked rising edge interrupts
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module apb_gpio (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic [`N_GPIO-1:0]       gpio_in_i,
  output logic [`N_GPIO-1:0]       gpio_out_o,
  output logic [`N_GPIO-1:0]       gpio_oe_o,
  output logic                     irq_o
);

  logic [`REG_OFFS_MSB:0] offs;
  logic                   wr_en;
  logic                   rd_clr;      // status read, clears at end of access
  logic [`N_GPIO-1:0]     gpio_sync;   // pins after synchronizer
  logic [`N_GPIO-1:0]     gpio_rise;   // rising edge pulses
  logic [`N_GPIO-1:0]     dir_q;
  logic [`N_GPIO-1:0]     out_q;
  logic [`N_GPIO-1:0]     inten_q;
  logic [`N_GPIO-1:0]     status_q;

  assign offs   = apb_req_i.paddr[`REG_OFFS_MSB:0];
  assign wr_en  = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
  assign rd_clr = apb_req_i.psel && apb_req_i.penable && !apb_req_i.pwrite &&
                  offs == `GPIO_INTSTATUS;

  ////////////////////
  // input sync
  ////////////////////
  sync_wedge #(
    .T(logic [`N_GPIO-1:0])
  ) i_gpio_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .serial_i(gpio_in_i),
    .serial_o(gpio_sync),
    .r_edge_o(gpio_rise),
    .f_edge_o()            // falling edges raise nothing here
  );

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      inten_q  <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && offs == `GPIO_DIR) dir_q <= apb_req_i.pwdata;
      if (wr_en && offs == `GPIO_OUT) out_q <= apb_req_i.pwdata;
      if (wr_en && offs == `GPIO_INTEN) inten_q <= apb_req_i.pwdata;
      // a new edge in the clearing cycle still gets recorded
      status_q <= (rd_clr ? '0 : status_q) | (gpio_rise & inten_q);
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;   // 1 drives the pin
  assign irq_o      = |status_q;

  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (offs)
      `GPIO_DIR:       apb_rsp_o.prdata = dir_q;
      `GPIO_OUT:       apb_rsp_o.prdata = out_q;
      `GPIO_IN:        apb_rsp_o.prdata = gpio_sync;
      `GPIO_INTEN:     apb_rsp_o.prdata = inten_q;
      `GPIO_INTSTATUS: apb_rsp_o.prdata = status_q;
      default:         apb_rsp_o.prdata = '0;
    endcase
  end

endmodule

//--- timer/apb_timer_unit.sv
// 32-bit timer on system clock or reference clock edges, compare-and-clear with interrupt pulse
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module apb_timer_unit (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic                     ref_rise_i,   // synchronized ref clock rise
  input  logic                     stoptimer_i,  // debug halt
  output logic                     irq_o
);

  logic [`REG_OFFS_MSB:0] offs;
  logic                   wr_en;
  logic                   wr_count;
  logic                   tick;     // increment this cycle
  logic                   match;    // compare hit on a tick
  logic [1:0]             cfg_q;    // [0] enable, [1] ref mode
  logic [31:0]            count_q;
  logic [31:0]            cmp_q;
  logic                   irq_q;

  assign offs     = apb_req_i.paddr[`REG_OFFS_MSB:0];
  assign wr_en    = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
  assign wr_count = wr_en && offs == `TIMER_COUNT;

  ////////////////////
  // tick source
  ////////////////////
  assign tick  = cfg_q[0] && !stoptimer_i && (cfg_q[1] ? ref_rise_i : 1'b1);
  assign match = tick && (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q   <= '0;
      count_q <= '0;
      cmp_q   <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (wr_en && offs == `TIMER_CFG) cfg_q <= apb_req_i.pwdata[1:0];
      if (wr_en && offs == `TIMER_CMP) cmp_q <= apb_req_i.pwdata;
      // software write beats the increment
      if (wr_count) begin
        count_q <= apb_req_i.pwdata;
      end else if (tick) begin
        count_q <= match ? '0 : count_q + 32'd1;  // wrap on compare
      end
      irq_q <= match && !wr_count;  // no pulse when the tick was overridden
    end
  end

  assign irq_o = irq_q;

  ////////////////////
  // read back
  ////////////////////
  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (offs)
      `TIMER_CFG:   apb_rsp_o.prdata = {30'b0, cfg_q};
      `TIMER_COUNT: apb_rsp_o.prdata = count_q;
      `TIMER_CMP:   apb_rsp_o.prdata = cmp_q;
      default:      apb_rsp_o.prdata = '0;
    endcase
  end

  // with a nonzero compare the counter leaves the match value right after a hit
  // ref mode ticks are never back to back either
  irq_single_pulse : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (irq_o && cmp_q != '0) |=> !irq_o
  ) else $error("timer irq high two cycles in a row");

endmodule

//--- hw/soc_peripherals.sv
// top of the apb peripheral subsystem, bus decoder plus soc control, gpio and timer, fc event map
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module soc_peripherals (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      ref_clk_i,    // slow reference clock
  input  logic                      stoptimer_i,
  input  soc_periph_pkg::apb_req_t  apb_req_i,
  output soc_periph_pkg::apb_rsp_t  apb_rsp_o,
  input  logic [`N_GPIO-1:0]        gpio_in_i,
  output logic [`N_GPIO-1:0]        gpio_out_o,
  output logic [`N_GPIO-1:0]        gpio_oe_o,
  output logic [31:0]               fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  output soc_periph_pkg::fc_event_t fc_events_o
);

  soc_periph_pkg::apb_req_t [`N_PERIPH-1:0] slv_req;
  soc_periph_pkg::apb_rsp_t [`N_PERIPH-1:0] slv_rsp;

  logic soft_reset;
  logic periph_rst_n;  // gpio and timer reset
  logic ref_rise;
  logic ref_fall;
  logic timer_irq;
  logic gpio_irq;

  // soft reset comes from a flop, clean to use asynchronously
  assign periph_rst_n = arst_n_i & ~soft_reset;

  ////////////////////
  // bus and ref clock
  ////////////////////
  periph_bus_decoder i_periph_bus (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .apb_req_i(apb_req_i), .apb_rsp_o(apb_rsp_o),
    .slv_req_o(slv_req), .slv_rsp_i(slv_rsp)
  );

  sync_wedge #(.T(logic)) i_ref_clk_sync (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .serial_i(ref_clk_i),
    .serial_o(), .r_edge_o(ref_rise), .f_edge_o(ref_fall)
  );

  ////////////////////
  // peripherals
  ////////////////////
  apb_soc_ctrl i_apb_soc_ctrl (
    .clk_i(clk_i), .arst_n_i(arst_n_i),  // stays out of its own soft reset
    .apb_req_i(slv_req[`SOC_CTRL_IDX]), .apb_rsp_o(slv_rsp[`SOC_CTRL_IDX]),
    .fc_bootaddr_o(fc_bootaddr_o), .fc_fetchen_o(fc_fetchen_o), .soft_reset_o(soft_reset)
  );

  apb_gpio i_apb_gpio (
    .clk_i(clk_i), .arst_n_i(periph_rst_n),
    .apb_req_i(slv_req[`GPIO_IDX]), .apb_rsp_o(slv_rsp[`GPIO_IDX]),
    .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o), .irq_o(gpio_irq)
  );

  apb_timer_unit i_apb_timer_unit (
    .clk_i(clk_i), .arst_n_i(periph_rst_n),
    .apb_req_i(slv_req[`TIMER_IDX]), .apb_rsp_o(slv_rsp[`TIMER_IDX]),
    .ref_rise_i(ref_rise), .stoptimer_i(stoptimer_i), .irq_o(timer_irq)
  );

  // fc event map, unused bits tied low
  always_comb begin
    fc_events_o                   = '0;
    fc_events_o[`EVT_TIMER_MTIME] = timer_irq;  // mtime irq
    fc_events_o[`EVT_TIMER_LO]    = timer_irq;
    fc_events_o[`EVT_REF_RISE]    = ref_rise;
    fc_events_o[`EVT_REF_FALL]    = ref_fall;
    fc_events_o[`EVT_GPIO]        = gpio_irq;   // OR of pending gpio status
  end

endmodule

//--- tb/tb_soc_peripherals.sv
// testbench for the apb peripheral subsystem, drives the apb port and pins, checks by assertions
`timescale 1ns/10ps
`include "soc_periph_config.svh"

module tb_soc_peripherals;

  localparam int WAIT_CYCLES = 200;  // limit of every wait loop
  localparam logic [31:0] EVT_MASK = (32'd1 << `EVT_TIMER_MTIME) | (32'd1 << `EVT_TIMER_LO) |
                                     (32'd1 << `EVT_REF_RISE) | (32'd1 << `EVT_REF_FALL) |
                                     (32'd1 << `EVT_GPIO);

  logic                      clk;
  logic                      arst_n;
  logic                      ref_clk;
  logic                      stoptimer;
  soc_periph_pkg::apb_req_t  apb_req;
  soc_periph_pkg::apb_rsp_t  apb_rsp;
  logic [`N_GPIO-1:0]        gpio_in;
  logic [`N_GPIO-1:0]        gpio_out;
  logic [`N_GPIO-1:0]        gpio_oe;
  logic [31:0]               fc_bootaddr;
  logic                      fc_fetchen;
  soc_periph_pkg::fc_event_t fc_events;

  int          checks;
  int          errors;
  int          timeouts;
  logic [31:0] lfsr_q;  // random source state

  soc_peripherals soc_peripherals_i (
    .clk_i(clk), .arst_n_i(arst_n), .ref_clk_i(ref_clk), .stoptimer_i(stoptimer),
    .apb_req_i(apb_req), .apb_rsp_o(apb_rsp), .gpio_in_i(gpio_in), .gpio_out_o(gpio_out),
    .gpio_oe_o(gpio_oe), .fc_bootaddr_o(fc_bootaddr), .fc_fetchen_o(fc_fetchen),
    .fc_events_o(fc_events)
  );

  always #20 clk = ~clk;  // 40 ns period

  ////////////////////
  // helpers
  ////////////////////
  // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] reg_addr(input int slot, input logic [7:0] offs);
    return (32'(slot) << `PERIPH_SEL_LSB) | {24'b0, offs};  // slot in bits 11:8
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    timeouts++;
    $display("timed out waiting for %s", what);
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected 0x%08h, got 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_below(input string name, input logic [31:0] limit, input logic [31:0] act);
    checks++;
    assert (act < limit) else begin
      errors++;
      $display("ERROR %s: expected below 0x%08h, got 0x%08h", name, limit, act);
    end
  endtask

  ////////////////////
  // apb master
  ////////////////////
  task automatic apb_transfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
    int cnt;
    @(negedge clk);
    apb_req.paddr   = addr;  // setup phase
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = wr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;  // access phase
    #1;
    cnt = 0;
    while (!apb_rsp.pready && cnt < WAIT_CYCLES) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (!apb_rsp.pready) give_up("pready in an apb access phase");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);  // transfer ended on the posedge before
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_data;
    logic        unused_err;
    apb_transfer(addr, 1'b1, wdata, unused_data, unused_err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata, output logic slverr);
    apb_transfer(addr, 1'b0, 32'h0, rdata, slverr);
  endtask

  // polls one event bit at each falling edge
  task automatic wait_for_event(input int bit_idx, input string what);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!fc_events[bit_idx] && cnt < WAIT_CYCLES);
    if (!fc_events[bit_idx]) give_up(what);
  endtask

  ////////////////////
  // concurrent checks
  ////////////////////
  pready_in_access : assert property (
    @(posedge clk) disable iff (!arst_n)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
  ) else begin
    errors++;
    $display("ERROR pready: expected 0x1, got 0x0 in an access phase");
  end

  unused_events_low : assert property (
    @(posedge clk) disable iff (!arst_n)
    (fc_events & ~EVT_MASK) == 32'h0
  ) else begin
    errors++;
    $display("ERROR fc_events_o: expected 0x%08h, got 0x%08h", fc_events & EVT_MASK, fc_events);
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    logic [31:0] rdata;
    logic        slverr;
    logic [31:0] boot_val;
    logic [31:0] val;
    logic [31:0] cnt_a;
    int          pin;
    int          other;
    int          n_edges;
    clk       = 1'b0;
    arst_n    = 1'b0;
    ref_clk   = 1'b0;
    stoptimer = 1'b0;
    apb_req   = '0;
    gpio_in   = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    lfsr_q    = 32'he2bf_5d1b;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    check_value("fc_fetchen_o", 32'h0, {31'b0, fc_fetchen});  // reset state
    check_value("gpio_oe_o", 32'h0, gpio_oe);
    check_value("gpio_out_o", 32'h0, gpio_out);
    check_value("fc_events_o", 32'h0, fc_events);
    check_value("fc_bootaddr_o", `BOOTADDR_RESET, fc_bootaddr);

    // soc control
    apb_read(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_INFO), rdata, slverr);
    check_value("INFO", `SOC_INFO_VALUE, rdata);
    apb_read(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_BOOTADDR), rdata, slverr);
    check_value("BOOTADDR", `BOOTADDR_RESET, rdata);
    boot_val = take_bits(32);
    apb_write(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_BOOTADDR), boot_val);
    check_value("fc_bootaddr_o", boot_val, fc_bootaddr);
    apb_read(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_BOOTADDR), rdata, slverr);
    check_value("BOOTADDR", boot_val, rdata);
    apb_write(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_FETCHEN), 32'h1);
    check_value("fc_fetchen_o", 32'h1, {31'b0, fc_fetchen});
    apb_read(reg_addr(5, 8'h00), rdata, slverr);  // hole in the map
    check_value("pslverr", 32'h1, {31'b0, slverr});
    check_value("prdata", 32'h0, rdata);

    // gpio direction, output and input
    val = take_bits(32);
    apb_write(reg_addr(`GPIO_IDX, `GPIO_DIR), val);
    check_value("gpio_oe_o", val, gpio_oe);
    val = take_bits(32);
    apb_write(reg_addr(`GPIO_IDX, `GPIO_OUT), val);
    check_value("gpio_out_o", val, gpio_out);
    val = take_bits(32);
    gpio_in = val;
    repeat (3) @(negedge clk);  // through the synchronizer
    apb_read(reg_addr(`GPIO_IDX, `GPIO_IN), rdata, slverr);
    check_value("IN", val, rdata);

    // gpio interrupt, only falling edges so far
    gpio_in = '0;
    repeat (4) @(negedge clk);
    apb_read(reg_addr(`GPIO_IDX, `GPIO_INTSTATUS), rdata, slverr);
    check_value("INTSTATUS", 32'h0, rdata);
    pin   = int'(take_bits(5));
    other = (pin + 1) % `N_GPIO;  // stays masked
    apb_write(reg_addr(`GPIO_IDX, `GPIO_INTEN), 32'd1 << pin);
    gpio_in[pin] = 1'b1;
    wait_for_event(`EVT_GPIO, "the gpio interrupt event");
    apb_read(reg_addr(`GPIO_IDX, `GPIO_INTSTATUS), rdata, slverr);
    check_value("INTSTATUS", 32'd1 << pin, rdata);
    check_value("fc_events_o[20]", 32'h0, {31'b0, fc_events[`EVT_GPIO]});  // cleared by read
    gpio_in[other] = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_value("fc_events_o[20]", 32'h0, {31'b0, fc_events[`EVT_GPIO]});
    end

    // timer compare on system clock
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CMP), 32'd5);
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CFG), 32'h1);
    wait_for_event(`EVT_TIMER_MTIME, "the timer compare event");
    check_value("fc_events_o[16]", 32'h1, {31'b0, fc_events[`EVT_TIMER_LO]});  // same pulse
    apb_read(reg_addr(`TIMER_IDX, `TIMER_COUNT), rdata, slverr);
    check_below("COUNT", 32'd6, rdata);
    stoptimer = 1'b1;
    apb_read(reg_addr(`TIMER_IDX, `TIMER_COUNT), cnt_a, slverr);
    apb_read(reg_addr(`TIMER_IDX, `TIMER_COUNT), rdata, slverr);
    check_value("COUNT", cnt_a, rdata);  // frozen
    stoptimer = 1'b0;

    // timer on reference clock rising edges
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CFG), 32'h0);
    apb_write(reg_addr(`TIMER_IDX, `TIMER_COUNT), 32'h0);
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CMP), 32'hffff_ffff);  // no wrap here
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CFG), 32'h3);
    n_edges = int'(take_bits(3)) + 2;
    repeat (n_edges) begin
      ref_clk = 1'b1;
      wait_for_event(`EVT_REF_RISE, "the reference clock rise event");
      ref_clk = 1'b0;
      wait_for_event(`EVT_REF_FALL, "the reference clock fall event");
    end
    apb_read(reg_addr(`TIMER_IDX, `TIMER_COUNT), rdata, slverr);
    check_value("COUNT", 32'(n_edges), rdata);

    // soft reset hits gpio and timer, not soc control
    val = take_bits(32) | 32'h1;
    apb_write(reg_addr(`GPIO_IDX, `GPIO_DIR), val);
    apb_write(reg_addr(`GPIO_IDX, `GPIO_OUT), val);
    apb_write(reg_addr(`TIMER_IDX, `TIMER_CFG), 32'h1);
    apb_write(reg_addr(`SOC_CTRL_IDX, `SOC_CTRL_SOFT_RESET), 32'h1);
    check_value("gpio_out_o", 32'h0, gpio_out);
    check_value("gpio_oe_o", 32'h0, gpio_oe);
    check_value("fc_bootaddr_o", boot_val, fc_bootaddr);
    apb_read(reg_addr(`TIMER_IDX, `TIMER_CFG), rdata, slverr);
    check_value("CFG", 32'h0, rdata);

    finish_run();
  end

endmodule

//--- filelist.f
+incdir+common
common/soc_periph_pkg.sv
hw/sync_wedge.sv
hw/periph_bus_decoder.sv
hw/apb_soc_ctrl.sv
gpio/apb_gpio.sv
timer/apb_timer_unit.sv
hw/soc_peripherals.sv
tb/tb_soc_peripherals.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, log in sim.log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  --top-module tb_soc_peripherals -f filelist.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
